// File: hw/isa_consts.svh
// shared constants for the instruction alignment front end
// parcel width, buffer depth and parcel address width
// 6-bit opcode encodings, found in the top bits of the first parcel

`ifndef ISA_CONSTS_SVH
`define ISA_CONSTS_SVH

// ========================================
// sizes
// ========================================

// bits per parcel, the opcode takes the top six
`define PARCEL_W 13
// parcel slots in the alignment buffer
`define BUF_DEPTH 8
// width of the running parcel address
`define ADDR_W 16

// ========================================
// opcodes
// ========================================

// arithmetic and logic, register and immediate forms
`define ADD_3R   6'h00
`define ADD_I23  6'h01
`define ADD_I36  6'h02
`define JMP      6'h03
`define ASL_3R   6'h04
`define SUB_3R   6'h05
`define SUB_I23  6'h06
`define SUB_I36  6'h07
`define JSR      6'h08
`define LSR_3R   6'h09
`define RETGRP   6'h0A
`define ROL_3R   6'h0B
`define AND_3R   6'h0C
`define AND_I23  6'h0D
`define AND_I36  6'h0E
`define BRKGRP   6'h0F
`define ROR_3R   6'h10
`define OR_3R    6'h11
`define OR_I23   6'h12
`define OR_I36   6'h13
`define JMP_RN   6'h14
`define SEP      6'h15
`define EOR_3R   6'h16
`define EOR_I23  6'h17
`define EOR_I36  6'h18
`define JSR_RN   6'h19
`define REP      6'h1A

// loads, stores and stack operations
`define LD_D9    6'h20
`define LD_D23   6'h21
`define LD_D36   6'h22
`define LDB_D36  6'h23
`define PLP      6'h24
`define POP      6'h25
`define ST_D9    6'h28
`define ST_D23   6'h29
`define ST_D36   6'h2A
`define STB_D36  6'h2B
`define PHP      6'h2C
`define PSH      6'h2D

// conditional branches, short and long displacement
`define BccD4a   6'h30
`define BccD4b   6'h31
`define BccD17a  6'h32
`define BccD17b  6'h33

`endif

// File: hw/isa_pkg.sv
// types shared by the alignment front end
// parcel, instruction length, fetch group and aligned instruction

`include "isa_consts.svh"

package isa_pkg;

  // one instruction parcel
  typedef logic [`PARCEL_W-1:0] parcelT;

  // instruction length in parcels, only 1 to 4 are legal
  typedef logic [2:0] lenT;

  // four parcels as delivered by fetch
  // slot 0 holds the lowest address
  typedef struct packed {
    parcelT [3:0] slot;
  } fetchGroupT;

  // one aligned instruction as presented to issue
  typedef struct packed {
    // opcode copied from the first parcel
    logic [5:0]         opcode;
    lenT                len;
    // parcel address of the first parcel
    logic [`ADDR_W-1:0] addr;
    // parcels past len are always zero
    parcelT [3:0]       parcel;
  } instT;

endpackage

// File: hw/instLength.sv
// opcode to instruction length table
// register forms, short displacements and long branches take two parcels,
// 23-bit forms three, 36-bit forms and absolute jumps four, the rest one

`timescale 1ns/10ps

`include "isa_consts.svh"

module instLength (
  input  logic [5:0]   opcode,
  output isa_pkg::lenT len
);

  // ========================================
  // length table
  // ========================================

  always_comb begin
    case (opcode)
      `ADD_3R:  len = 3'd2;
      `ADD_I23: len = 3'd3;
      `ADD_I36: len = 3'd4;
      `JMP:     len = 3'd4;
      `ASL_3R:  len = 3'd2;
      `SUB_3R:  len = 3'd2;
      `SUB_I23: len = 3'd3;
      `SUB_I36: len = 3'd4;
      `JSR:     len = 3'd4;
      `LSR_3R:  len = 3'd2;
      `RETGRP:  len = 3'd1;
      `ROL_3R:  len = 3'd2;
      `AND_3R:  len = 3'd2;
      `AND_I23: len = 3'd3;
      `AND_I36: len = 3'd4;
      `BRKGRP:  len = 3'd1;
      `ROR_3R:  len = 3'd2;
      `OR_3R:   len = 3'd2;
      `OR_I23:  len = 3'd3;
      `OR_I36:  len = 3'd4;
      `JMP_RN:  len = 3'd1;
      `SEP:     len = 3'd1;
      `EOR_3R:  len = 3'd2;
      `EOR_I23: len = 3'd3;
      `EOR_I36: len = 3'd4;
      `JSR_RN:  len = 3'd1;
      `REP:     len = 3'd1;
      // memory access, the displacement width sets the length
      `LD_D9:   len = 3'd2;
      `LD_D23:  len = 3'd3;
      `LD_D36:  len = 3'd4;
      `LDB_D36: len = 3'd4;
      `PLP:     len = 3'd1;
      `POP:     len = 3'd1;
      `ST_D9:   len = 3'd2;
      `ST_D23:  len = 3'd3;
      `ST_D36:  len = 3'd4;
      `STB_D36: len = 3'd4;
      `PHP:     len = 3'd1;
      `PSH:     len = 3'd1;
      // 4-bit branches fit in the opcode parcel
      `BccD4a:  len = 3'd1;
      `BccD4b:  len = 3'd1;
      `BccD17a: len = 3'd2;
      `BccD17b: len = 3'd2;
      // unimplemented opcodes still advance by one parcel
      default:  len = 3'd1;
    endcase
  end

endmodule

// File: hw/parcelBuffer.sv
// parcel queue between fetch and the aligner
// drops consumed parcels from the head and appends fetch groups behind
// the survivors, all in the same edge

`timescale 1ns/10ps

`include "isa_consts.svh"

module parcelBuffer (
  input  logic               clk,
  input  logic               arstN,
  input  isa_pkg::fetchGroupT fetchGroup,
  input  logic               fetchValid,
  input  isa_pkg::lenT       consume,
  output isa_pkg::fetchGroupT window,
  output logic [3:0]         level,
  output logic               fetchReady
);

  // ========================================
  // storage
  // ========================================

  // slot 0 is always the head of the queue
  isa_pkg::parcelT slot     [`BUF_DEPTH];
  isa_pkg::parcelT nextSlot [`BUF_DEPTH];

  // parcels left over once the head has been retired
  logic [3:0] remain;
  // a fetch group is taken this edge
  logic       accept;

  // room for a whole group is needed before fetch may send one
  assign fetchReady = (level <= 4'(`BUF_DEPTH - 4));
  // a strobe that arrives while not ready is simply dropped
  assign accept     = fetchValid && fetchReady;

  // the aligner never retires more than level, so this cannot wrap
  assign remain = level - {1'b0, consume};

  // ========================================
  // next state of the slots
  // ========================================

  always_comb begin
    for (int i = 0; i < `BUF_DEPTH; i++) begin
      // shift survivors toward the head by the number consumed
      if (i + consume < `BUF_DEPTH) begin
        nextSlot[i] = slot[3'(i + consume)];
      end else begin
        // slots past the survivors are free and their content does not matter
        nextSlot[i] = slot[i];
      end
      // new parcels land right behind the survivors in slot order
      if (accept && (i >= remain) && (i < remain + 4'd4)) begin
        nextSlot[i] = fetchGroup.slot[2'(i - remain)];
      end
    end
  end

  // level alone tells which slots hold data
  always_ff @(posedge clk) begin
    for (int i = 0; i < `BUF_DEPTH; i++) begin
      slot[i] <= nextSlot[i];
    end
  end

  // ========================================
  // fill level
  // ========================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      level <= '0;
    end else if (accept) begin
      level <= remain + 4'd4;
    end else begin
      level <= remain;
    end
  end

  // ========================================
  // head window
  // ========================================

  // the aligner sees the four head slots, some of which may be stale
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      window.slot[k] = slot[k];
    end
  end

endmodule

// File: hw/instAligner.sv
// aligner that cuts the head instruction out of the buffer window
// looks up the length, decides on issue and keeps the parcel address

`timescale 1ns/10ps

`include "isa_consts.svh"

module instAligner (
  input  logic                clk,
  input  logic                arstN,
  input  isa_pkg::fetchGroupT window,
  input  logic [3:0]          level,
  input  logic                issueOpen,
  output isa_pkg::lenT        consume,
  output isa_pkg::instT       inst,
  output logic                instIssue
);

  // ========================================
  // length decode
  // ========================================

  logic [5:0]         opcode;
  isa_pkg::lenT       headLen;
  // address of the parcel now at the head of the buffer
  logic [`ADDR_W-1:0] addr;

  // opcode sits in the top six bits of the head parcel
  assign opcode = window.slot[0][`PARCEL_W-1 -: 6];

  instLength i_instLength (
    .opcode (opcode),
    .len    (headLen)
  );

  // ========================================
  // issue decision
  // ========================================

  // every length is at least one, so an empty buffer never issues
  assign instIssue = issueOpen && (level >= {1'b0, headLen});
  // the buffer retires exactly what is issued
  assign consume   = instIssue ? headLen : 3'd0;

  // ========================================
  // instruction build
  // ========================================

  always_comb begin
    inst.opcode = opcode;
    inst.len    = headLen;
    inst.addr   = addr;
    for (int k = 0; k < 4; k++) begin
      // parcels that belong to the next instruction are masked off
      if (k < headLen) begin
        inst.parcel[k] = window.slot[k];
      end else begin
        inst.parcel[k] = '0;
      end
    end
  end

  // addresses run without gaps and step by len on each issue
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      addr <= '0;
    end else if (instIssue) begin
      addr <= addr + {{(`ADDR_W - 3){1'b0}}, headLen};
    end
  end

endmodule

// File: hw/issueRegister.sv
// output register holding one aligned instruction
// loads on issue, drops valid once taken, holds under stall

`timescale 1ns/10ps

module issueRegister (
  input  logic          clk,
  input  logic          arstN,
  input  isa_pkg::instT inst,
  input  logic          instIssue,
  input  logic          stall,
  output isa_pkg::instT instOut,
  output logic          instValid,
  output logic          issueOpen
);

  // ========================================
  // handshake
  // ========================================

  // free now, or the held instruction leaves at this edge
  assign issueOpen = !instValid || !stall;

  // valid flag, cleared only when the consumer takes the instruction
  // and the aligner has nothing new behind it
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instValid <= 1'b0;
    end else if (instIssue) begin
      instValid <= 1'b1;
    end else if (instValid && !stall) begin
      instValid <= 1'b0;
    end
  end

  // ========================================
  // payload
  // ========================================

  // instIssue only rises while issueOpen, so a stalled value is never
  // overwritten
  always_ff @(posedge clk) begin
    if (instIssue) begin
      instOut <= inst;
    end
  end

endmodule

// File: hw/instFetchAlign.sv
// top level of the alignment front end
// parcel buffer feeding the aligner, aligner feeding the issue register

`timescale 1ns/10ps

module instFetchAlign (
  input  logic                clk,
  input  logic                arstN,
  input  isa_pkg::fetchGroupT fetchGroup,
  input  logic                fetchValid,
  output logic                fetchReady,
  input  logic                stall,
  output isa_pkg::instT       instOut,
  output logic                instValid
);

  // buffer to aligner
  isa_pkg::fetchGroupT window;
  logic [3:0]          level;
  // aligner back to buffer
  isa_pkg::lenT        consume;
  // aligner to issue register and back
  isa_pkg::instT       inst;
  logic                instIssue;
  logic                issueOpen;

  parcelBuffer i_parcelBuffer (
    .clk        (clk),
    .arstN      (arstN),
    .fetchGroup (fetchGroup),
    .fetchValid (fetchValid),
    .consume    (consume),
    .window     (window),
    .level      (level),
    .fetchReady (fetchReady)
  );

  instAligner i_instAligner (
    .clk       (clk),
    .arstN     (arstN),
    .window    (window),
    .level     (level),
    .issueOpen (issueOpen),
    .consume   (consume),
    .inst      (inst),
    .instIssue (instIssue)
  );

  issueRegister i_issueRegister (
    .clk       (clk),
    .arstN     (arstN),
    .inst      (inst),
    .instIssue (instIssue),
    .stall     (stall),
    .instOut   (instOut),
    .instValid (instValid),
    .issueOpen (issueOpen)
  );

endmodule

// File: sim/instFetchAlign_tb.sv
// testbench for the instruction alignment front end
// builds instruction programs, packs them into fetch groups and checks
// every issued instruction against a queue built from the length rule

`timescale 1ns/10ps

`include "isa_consts.svh"

module instFetchAlign_tb;

  // opcodes that the length rule names, all other values are unassigned
  localparam logic [5:0] opList [43] = '{
    `ADD_3R, `ADD_I23, `ADD_I36, `JMP, `ASL_3R, `SUB_3R, `SUB_I23, `SUB_I36, `JSR,
    `LSR_3R, `RETGRP, `ROL_3R, `AND_3R, `AND_I23, `AND_I36, `BRKGRP, `ROR_3R, `OR_3R,
    `OR_I23, `OR_I36, `JMP_RN, `SEP, `EOR_3R, `EOR_I23, `EOR_I36, `JSR_RN, `REP,
    `LD_D9, `LD_D23, `LD_D36, `LDB_D36, `PLP, `POP, `ST_D9, `ST_D23, `ST_D36,
    `STB_D36, `PHP, `PSH, `BccD4a, `BccD4b, `BccD17a, `BccD17b
  };

  logic                clk;
  logic                arstN;
  isa_pkg::fetchGroupT fetchGroup;
  logic                fetchValid;
  logic                fetchReady;
  logic                stall;
  isa_pkg::instT       instOut;
  logic                instValid;

  integer              seed = 32'h735d8788;
  int                  errors;
  int                  checks;
  int                  cycles;
  // the timeout grows with the number of parcels sent so far
  int                  totalParcels;
  string               testName;
  logic                stallOn;
  logic                sawFull;
  logic                holdLast;
  isa_pkg::instT       lastOut;
  isa_pkg::instT       expInst;
  logic [`ADDR_W-1:0]  nextAddr;
  isa_pkg::parcelT     parcelQ [$];
  isa_pkg::instT       expQ [$];

  instFetchAlign i_dut (
    .clk        (clk),
    .arstN      (arstN),
    .fetchGroup (fetchGroup),
    .fetchValid (fetchValid),
    .fetchReady (fetchReady),
    .stall      (stall),
    .instOut    (instOut),
    .instValid  (instValid)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ========================================
  // reference model
  // ========================================

  // length in parcels by the operand form of each opcode
  function automatic isa_pkg::lenT refLen(input logic [5:0] op);
    case (op)
      `ADD_3R, `ASL_3R, `SUB_3R, `LSR_3R, `ROL_3R, `AND_3R, `ROR_3R, `OR_3R, `EOR_3R,
      `LD_D9, `ST_D9, `BccD17a, `BccD17b: return 3'd2;
      `ADD_I23, `SUB_I23, `AND_I23, `OR_I23, `EOR_I23, `LD_D23, `ST_D23: return 3'd3;
      `ADD_I36, `SUB_I36, `AND_I36, `OR_I36, `EOR_I36, `LD_D36, `LDB_D36, `ST_D36,
      `STB_D36, `JMP, `JSR: return 3'd4;
      `RETGRP, `BRKGRP, `JMP_RN, `JSR_RN, `SEP, `REP, `PLP, `POP, `PHP, `PSH,
      `BccD4a, `BccD4b: return 3'd1;
      // unassigned opcodes still take one parcel
      default: return 3'd1;
    endcase
  endfunction

  function automatic logic isListed(input logic [5:0] op);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 43; i++) begin
      if (opList[i] == op) hit = 1'b1;
    end
    return hit;
  endfunction

  // appends one instruction with random operands to the program
  // and the matching entry to the expected queue
  task automatic addInst(input logic [5:0] op);
    isa_pkg::instT   e;
    isa_pkg::lenT    n;
    isa_pkg::parcelT p;
    n = refLen(op);
    e = '0;
    e.opcode = op;
    e.len    = n;
    e.addr   = nextAddr;
    for (int k = 0; k < n; k++) begin
      p = isa_pkg::parcelT'($random(seed));
      if (k == 0) p[`PARCEL_W-1 -: 6] = op;
      e.parcel[k] = p;
      parcelQ.push_back(p);
    end
    nextAddr     = nextAddr + `ADDR_W'(n);
    totalParcels = totalParcels + n;
    expQ.push_back(e);
  endtask

  // ========================================
  // stimulus
  // ========================================

  // pads to whole groups with one-parcel SEP instructions, then sends
  task automatic sendProgram();
    isa_pkg::fetchGroupT g;
    while (parcelQ.size() % 4 != 0) addInst(`SEP);
    while (parcelQ.size() != 0) begin
      for (int k = 0; k < 4; k++) g.slot[k] = parcelQ.pop_front();
      @(posedge clk);
      fetchGroup <= g;
      fetchValid <= 1'b1;
      // the strobe stays up until a cycle with fetchReady high takes it
      do @(negedge clk); while (!fetchReady);
    end
    @(posedge clk);
    fetchValid <= 1'b0;
  endtask

  task automatic drain();
    while (expQ.size() != 0) @(negedge clk);
  endtask

  // stall is random only in the stall test
  always @(posedge clk) begin
    if (stallOn) stall <= ($random(seed) % 2) != 0;
    else stall <= 1'b0;
  end

  // ========================================
  // compare tasks and report
  // ========================================

  task automatic checkInst(input string name, input isa_pkg::instT exp,
                           input isa_pkg::instT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $write("Error %s: expected op %h len %0d addr %h parcels %h", name,
             exp.opcode, exp.len, exp.addr, exp.parcel);
      $display(", actual op %h len %0d addr %h parcels %h",
               act.opcode, act.len, act.addr, act.parcel);
    end
  endtask

  task automatic checkLen(input string name, input isa_pkg::lenT exp, input isa_pkg::lenT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected length %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic finishRun();
    $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // outputs are sampled at the falling edge where they are stable
  always @(negedge clk) begin
    if (arstN) begin
      if (!fetchReady) sawFull = 1'b1;
      // a stalled instruction must stay put
      if (holdLast) begin
        checkBit({testName, " stall hold valid"}, 1'b1, instValid);
        checkInst({testName, " stall hold"}, lastOut, instOut);
      end
      if (instValid && !stall) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("instruction at address %h was issued but none was expected",
                   instOut.addr);
        end else begin
          expInst = expQ.pop_front();
          checkLen(testName, expInst.len, instOut.len);
          checkInst(testName, expInst, instOut);
        end
      end
      holdLast = instValid && stall;
      lastOut  = instOut;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 4 * totalParcels + 200) begin
      errors++;
      $display("timeout after %0d cycles with %0d instructions never issued",
               cycles, expQ.size());
      finishRun();
    end
  end

  // ========================================
  // test sequence
  // ========================================

  initial begin
    arstN      = 1'b0;
    fetchValid = 1'b0;
    fetchGroup = '0;
    stall      = 1'b0;
    stallOn    = 1'b0;
    holdLast   = 1'b0;
    sawFull    = 1'b0;
    nextAddr   = '0;
    testName   = "reset";
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkBit("reset instValid", 1'b0, instValid);
    checkBit("reset fetchReady", 1'b1, fetchReady);

    // every listed opcode heads a program of its own
    testName = "length table";
    for (int i = 0; i < 43; i++) begin
      addInst(opList[i]);
      sendProgram();
      drain();
    end

    testName = "unassigned opcode";
    for (int op = 0; op < 64; op++) begin
      if (!isListed(6'(op))) begin
        addInst(6'(op));
        sendProgram();
        drain();
      end
    end

    // random opcodes over the full range make instructions straddle groups
    testName = "random stream";
    for (int i = 0; i < 60; i++) addInst(6'($random(seed)));
    sendProgram();
    drain();

    testName = "random stall";
    sawFull  = 1'b0;
    stallOn  = 1'b1;
    for (int i = 0; i < 60; i++) addInst(6'($random(seed)));
    sendProgram();
    stallOn = 1'b0;
    drain();
    checkBit("random stall fetchReady dropped", 1'b1, sawFull);

    // a few idle cycles to catch any extra instruction
    repeat (8) @(negedge clk);
    finishRun();
  end

endmodule

// File: instFetchAlign.f
+incdir+hw
hw/isa_pkg.sv
hw/instLength.sv
hw/parcelBuffer.sv
hw/instAligner.sv
hw/issueRegister.sv
hw/instFetchAlign.sv
sim/instFetchAlign_tb.sv

// File: Bender.yml
package:
  name: inst_fetch_align

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/instLength.sv
      - hw/parcelBuffer.sv
      - hw/instAligner.sv
      - hw/issueRegister.sv
      - hw/instFetchAlign.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/instFetchAlign_tb.sv
